// ==== intr_pkg.sv ====
`default_nettype none

package intr_pkg;

    //////////////////////////////////////////////////////////////////////
    // tlp header codes and bar select
    //////////////////////////////////////////////////////////////////////

    localparam logic [6:0] MEM_WR32_FMT_TYPE = 7'b10_00000;    // 3dw header with data
    localparam logic [6:0] MEM_WR64_FMT_TYPE = 7'b11_00000;    // 4dw header with data

    localparam int REG_BAR = 2;                                 // active-low hit bit

    //////////////////////////////////////////////////////////////////////
    // register map, dword offsets inside the bar
    //////////////////////////////////////////////////////////////////////

    localparam logic [5:0] OFS_ENABLE  = 6'h08;
    localparam logic [5:0] OFS_DISABLE = 6'h09;
    localparam logic [5:0] OFS_PERIOD  = 6'h0A;
    localparam logic [5:0] OFS_RTT     = 6'h0B;   // round-trip test irq

    localparam logic [31:0] PERIOD_RESET = 32'h0003_D090;

    // command fifo sizing
    localparam int CMD_FIFO_DEPTH = 4;
    localparam int CMD_PTR_W      = $clog2(CMD_FIFO_DEPTH);
    localparam int CMD_CNT_W      = $clog2(CMD_FIFO_DEPTH + 1);

    typedef enum logic [1:0] {
        OP_ENABLE  = 2'd0,
        OP_DISABLE = 2'd1,
        OP_PERIOD  = 2'd2,
        OP_RTT     = 2'd3
    } reg_op_e;

    typedef enum logic [1:0] {
        DEC_IDLE      = 2'd0,    // waiting for a header
        DEC_MW32      = 2'd1,    // addr + data beat of a 3dw write
        DEC_MW64_ADDR = 2'd2,    // addr beat of a 4dw write
        DEC_MW64_DATA = 2'd3     // data beat of a 4dw period write
    } dec_state_e;

endpackage

`default_nettype wire

// ==== tlp_reg_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module tlp_reg_decoder
    import intr_pkg::*;
(
    input  wire         trn_clk,
    input  wire         reset,

    // trn receive side, observed only
    input  wire  [63:0] trn_rd_i,
    input  wire         trn_rsof_n_i,
    input  wire         trn_rsrc_rdy_n_i,
    input  wire         trn_rdst_rdy_n_i,
    input  wire  [6:0]  trn_rbar_hit_n_i,

    // command push toward the fifo
    output logic        cmd_wr_o,
    output reg_op_e     cmd_op_o,
    output logic [31:0] cmd_data_o
);

    dec_state_e  state_q;
    logic        beat;          // beat accepted by both ends
    logic        hdr_hit;       // sof on the register bar
    logic [6:0]  fmt_type;
    logic [5:0]  ofs;
    logic        ofs_hit;
    reg_op_e     ofs_op;

    //////////////////////////////////////////////////////////////////////
    // beat qualification and offset decode
    //////////////////////////////////////////////////////////////////////

    assign beat     = !trn_rsrc_rdy_n_i && !trn_rdst_rdy_n_i;
    assign hdr_hit  = beat && !trn_rsof_n_i && !trn_rbar_hit_n_i[REG_BAR];
    assign fmt_type = trn_rd_i[62:56];                  // fmt + type of dw0

    // 3dw write: dw2 sits in the upper half of beat 2
    // 4dw write: low address dword sits in the lower half
    assign ofs = (state_q == DEC_MW32) ? trn_rd_i[39:34] : trn_rd_i[7:2];

    always_comb begin
        ofs_hit = 1'b1;
        ofs_op  = OP_ENABLE;
        case (ofs)
            OFS_ENABLE:  ofs_op = OP_ENABLE;
            OFS_DISABLE: ofs_op = OP_DISABLE;
            OFS_PERIOD:  ofs_op = OP_PERIOD;
            OFS_RTT:     ofs_op = OP_RTT;
            default:     ofs_hit = 1'b0;          // not a control register
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // tlp tracking fsm
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge trn_clk) begin
        if (reset) begin
            state_q  <= DEC_IDLE;
            cmd_wr_o <= 1'b0;
        end else begin
            cmd_wr_o <= 1'b0;                            // single-cycle strobe
            case (state_q)
                DEC_IDLE: begin
                    if (hdr_hit) begin
                        if (fmt_type == MEM_WR32_FMT_TYPE) begin
                            state_q <= DEC_MW32;
                        end else if (fmt_type == MEM_WR64_FMT_TYPE) begin
                            state_q <= DEC_MW64_ADDR;
                        end                              // reads, cpl: stay
                    end
                end
                DEC_MW32: begin
                    if (beat) begin
                        state_q  <= DEC_IDLE;
                        cmd_wr_o <= ofs_hit;             // data is in this beat
                    end
                end
                DEC_MW64_ADDR: begin
                    if (beat) begin
                        if (ofs_hit && (ofs_op == OP_PERIOD)) begin
                            state_q <= DEC_MW64_DATA;    // period needs the payload
                        end else begin
                            state_q  <= DEC_IDLE;
                            cmd_wr_o <= ofs_hit;
                        end
                    end
                end
                DEC_MW64_DATA: begin
                    if (beat) begin
                        state_q  <= DEC_IDLE;
                        cmd_wr_o <= 1'b1;
                    end
                end
                default: begin
                    state_q <= DEC_IDLE;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // command payload
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge trn_clk) begin
        if (beat) begin
            case (state_q)
                DEC_MW32: begin
                    cmd_op_o   <= ofs_op;
                    cmd_data_o <= trn_rd_i[31:0];        // dw3, raw host order
                end
                DEC_MW64_ADDR: begin
                    cmd_op_o   <= ofs_op;
                    cmd_data_o <= '0;                    // no payload for these ops
                end
                DEC_MW64_DATA: begin
                    cmd_op_o   <= OP_PERIOD;
                    cmd_data_o <= trn_rd_i[63:32];       // dw4 leads the beat
                end
                default: begin
                    cmd_op_o   <= cmd_op_o;
                    cmd_data_o <= cmd_data_o;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== reg_cmd_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_cmd_fifo
    import intr_pkg::*;
(
    input  wire         trn_clk,
    input  wire         reset,

    // push side
    input  wire         wr_i,
    input  var reg_op_e op_i,
    input  wire  [31:0] data_i,

    // pop side, head valid while not empty
    input  wire         rd_i,
    output reg_op_e     op_o,
    output logic [31:0] data_o,
    output logic        empty_o,
    output logic        full_o
);

    reg_op_e              op_mem   [CMD_FIFO_DEPTH];
    logic [31:0]          data_mem [CMD_FIFO_DEPTH];
    logic [CMD_PTR_W-1:0] wr_ptr_q;
    logic [CMD_PTR_W-1:0] rd_ptr_q;
    logic [CMD_CNT_W-1:0] count_q;
    logic                 push;
    logic                 pop;

    assign push = wr_i && !full_o;
    assign pop  = rd_i && !empty_o;

    // storage, no reset on payload
    always_ff @(posedge trn_clk) begin
        if (push) begin
            op_mem[wr_ptr_q]   <= op_i;
            data_mem[wr_ptr_q] <= data_i;
        end
    end

    always_ff @(posedge trn_clk) begin
        if (reset) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == CMD_PTR_W'(CMD_FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == CMD_PTR_W'(CMD_FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;     // idle or both at once
            endcase
        end
    end

    assign op_o    = op_mem[rd_ptr_q];                  // head, combinational
    assign data_o  = data_mem[rd_ptr_q];
    assign empty_o = (count_q == '0);
    assign full_o  = (count_q == CMD_CNT_W'(CMD_FIFO_DEPTH));

    a_no_wr_full: assert property (
        @(posedge trn_clk) disable iff (reset)
        wr_i |-> !full_o
    ) else $error("command fifo written while full");

    a_no_rd_empty: assert property (
        @(posedge trn_clk) disable iff (reset)
        rd_i |-> !empty_o
    ) else $error("command fifo read while empty");

endmodule

`default_nettype wire

// ==== intr_ctrl_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module intr_ctrl_regs
    import intr_pkg::*;
(
    input  wire         trn_clk,
    input  wire         reset,

    // command fifo head
    input  wire         cmd_empty_i,
    input  var reg_op_e cmd_op_i,
    input  wire  [31:0] cmd_data_i,
    output logic        cmd_rd_o,

    // levels for the dma engine
    output logic        interrupts_enabled_o,
    output logic [31:0] interrupt_period_o,

    // core interrupt handshake
    output logic        cfg_interrupt_n_o,
    input  wire         cfg_interrupt_rdy_n_i
);

    typedef enum logic {
        IRQ_IDLE = 1'b0,
        IRQ_WAIT = 1'b1     // request out, waiting for rdy
    } irq_state_e;

    irq_state_e  irq_state_q;
    logic        period_busy_q;     // swapped value waiting to commit
    logic [31:0] period_swap_q;
    logic        pop_enable;
    logic        pop_disable;
    logic        pop_period;
    logic        pop_rtt;

    //////////////////////////////////////////////////////////////////////
    // command pop
    //////////////////////////////////////////////////////////////////////

    assign cmd_rd_o    = !cmd_empty_i && !period_busy_q;   // hold off during commit
    assign pop_enable  = cmd_rd_o && (cmd_op_i == OP_ENABLE);
    assign pop_disable = cmd_rd_o && (cmd_op_i == OP_DISABLE);
    assign pop_period  = cmd_rd_o && (cmd_op_i == OP_PERIOD);
    assign pop_rtt     = cmd_rd_o && (cmd_op_i == OP_RTT);

    // host writes little endian, trn data is big endian
    always_ff @(posedge trn_clk) begin
        if (pop_period) begin
            period_swap_q <= {cmd_data_i[7:0], cmd_data_i[15:8],
                              cmd_data_i[23:16], cmd_data_i[31:24]};
        end
    end

    //////////////////////////////////////////////////////////////////////
    // enable and period registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge trn_clk) begin
        if (reset) begin
            interrupts_enabled_o <= 1'b1;
            interrupt_period_o   <= PERIOD_RESET;
            period_busy_q        <= 1'b0;
        end else begin
            if (pop_enable) begin
                interrupts_enabled_o <= 1'b1;
            end else if (pop_disable) begin
                interrupts_enabled_o <= 1'b0;
            end
            period_busy_q <= pop_period;                   // one-cycle commit slot
            if (period_busy_q) begin
                interrupt_period_o <= {2'b00, period_swap_q[31:2]};  // bytes to dwords
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // round-trip test interrupt
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge trn_clk) begin
        if (reset) begin
            irq_state_q       <= IRQ_IDLE;
            cfg_interrupt_n_o <= 1'b1;
        end else begin
            case (irq_state_q)
                IRQ_IDLE: begin
                    if (pop_rtt) begin
                        irq_state_q       <= IRQ_WAIT;
                        cfg_interrupt_n_o <= 1'b0;       // request to the core
                    end
                end
                IRQ_WAIT: begin
                    // rtt pops here fold into the pending request
                    if (!cfg_interrupt_rdy_n_i) begin
                        irq_state_q       <= IRQ_IDLE;
                        cfg_interrupt_n_o <= 1'b1;
                    end
                end
                default: begin
                    irq_state_q       <= IRQ_IDLE;
                    cfg_interrupt_n_o <= 1'b1;
                end
            endcase
        end
    end

    // request only drops after the core has acked it, or on reset
    a_irq_release: assert property (
        @(posedge trn_clk) disable iff (reset)
        $rose(cfg_interrupt_n_o) |-> ($past(reset) || !$past(cfg_interrupt_rdy_n_i))
    ) else $error("cfg_interrupt_n released without cfg_interrupt_rdy_n");

endmodule

`default_nettype wire

// ==== intr_ctrl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module intr_ctrl_top
    import intr_pkg::*;
(
    input  wire         trn_clk,
    input  wire         reset,

    // trn receive stream, monitored
    input  wire  [63:0] trn_rd_i,
    input  wire         trn_rsof_n_i,
    input  wire         trn_rsrc_rdy_n_i,
    input  wire         trn_rdst_rdy_n_i,
    input  wire  [6:0]  trn_rbar_hit_n_i,

    // core interrupt and dma-side levels
    input  wire         cfg_interrupt_rdy_n_i,
    output logic        cfg_interrupt_n_o,
    output logic        interrupts_enabled_o,
    output logic [31:0] interrupt_period_o
);

    logic        cmd_wr;        // decoder push
    reg_op_e     cmd_op;
    logic [31:0] cmd_data;
    logic        cmd_rd;        // controller pop
    reg_op_e     head_op;
    logic [31:0] head_data;
    logic        cmd_empty;
    logic        cmd_full;

    tlp_reg_decoder tlp_reg_decoder_inst (
        .trn_clk          (trn_clk),
        .reset            (reset),
        .trn_rd_i         (trn_rd_i),
        .trn_rsof_n_i     (trn_rsof_n_i),
        .trn_rsrc_rdy_n_i (trn_rsrc_rdy_n_i),
        .trn_rdst_rdy_n_i (trn_rdst_rdy_n_i),
        .trn_rbar_hit_n_i (trn_rbar_hit_n_i),
        .cmd_wr_o         (cmd_wr),
        .cmd_op_o         (cmd_op),
        .cmd_data_o       (cmd_data)
    );

    reg_cmd_fifo reg_cmd_fifo_inst (
        .trn_clk (trn_clk),
        .reset   (reset),
        .wr_i    (cmd_wr),
        .op_i    (cmd_op),
        .data_i  (cmd_data),
        .rd_i    (cmd_rd),
        .op_o    (head_op),
        .data_o  (head_data),
        .empty_o (cmd_empty),
        .full_o  (cmd_full)
    );

    intr_ctrl_regs intr_ctrl_regs_inst (
        .trn_clk               (trn_clk),
        .reset                 (reset),
        .cmd_empty_i           (cmd_empty),
        .cmd_op_i              (head_op),
        .cmd_data_i            (head_data),
        .cmd_rd_o              (cmd_rd),
        .interrupts_enabled_o  (interrupts_enabled_o),
        .interrupt_period_o    (interrupt_period_o),
        .cfg_interrupt_n_o     (cfg_interrupt_n_o),
        .cfg_interrupt_rdy_n_i (cfg_interrupt_rdy_n_i)
    );

    // decoder rate vs controller drain keeps the fifo from filling
    a_cmd_no_overflow: assert property (
        @(posedge trn_clk) disable iff (reset)
        cmd_wr |-> !cmd_full
    ) else $error("register command arrived with the fifo full");

endmodule

`default_nettype wire

// ==== tb_intr_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_intr_checker
    import intr_pkg::*;
(
    input  wire         trn_clk,
    input  wire         reset,
    input  wire         model_wr_i,             // intended command, one cycle
    input  var reg_op_e model_op_i,
    input  wire  [31:0] model_data_i,
    input  wire         check_req_i,            // stream quiet, compare levels
    input  wire         done_i,
    input  wire         interrupts_enabled_i,
    input  wire  [31:0] interrupt_period_i,
    input  wire         cfg_interrupt_n_i,
    input  wire         cfg_interrupt_rdy_n_i,
    output int          error_count_o,
    output int          check_count_o,
    output int          irq_expected_o,
    output int          irq_acked_o,
    output logic        report_done_o
);

    logic        m_enabled;
    logic [31:0] m_period;
    logic        m_pending;         // request out, no ack yet
    logic        pop_valid_q;       // lines up with the dut pop edge
    reg_op_e     pop_op_q;
    logic [31:0] pop_data_q;
    logic        check_armed_q;
    logic        release_due_q;     // rdy seen low with request out
    logic        irq_n_prev_q;

    function automatic logic [31:0] period_units(input logic [31:0] raw);
        logic [31:0] swapped;
        swapped = {raw[7:0], raw[15:8], raw[23:16], raw[31:24]};   // little endian host
        return swapped >> 2;                                        // bytes to dwords
    endfunction

    //////////////////////////////////////////////////////////////////////
    // reference model, stepped on rising edges
    //////////////////////////////////////////////////////////////////////

    always @(posedge trn_clk) begin
        if (reset) begin
            m_enabled      <= 1'b1;
            m_period       <= PERIOD_RESET;
            m_pending      <= 1'b0;
            pop_valid_q    <= 1'b0;
            check_armed_q  <= 1'b0;
            release_due_q  <= 1'b0;
            irq_expected_o <= 0;
        end else begin
            pop_valid_q   <= model_wr_i;        // fifo push one edge later
            pop_op_q      <= model_op_i;
            pop_data_q    <= model_data_i;
            check_armed_q <= check_req_i;
            release_due_q <= !cfg_interrupt_n_i && !cfg_interrupt_rdy_n_i;  // as the dut sees it
            if (pop_valid_q) begin
                case (pop_op_q)
                    OP_ENABLE:  m_enabled <= 1'b1;
                    OP_DISABLE: m_enabled <= 1'b0;
                    OP_PERIOD:  m_period  <= period_units(pop_data_q);
                    default:    m_enabled <= m_enabled;
                endcase
            end
            if (m_pending) begin
                if (!cfg_interrupt_rdy_n_i) begin
                    m_pending <= 1'b0;          // any rtt now is merged
                end
            end else if (pop_valid_q && (pop_op_q == OP_RTT)) begin
                m_pending      <= 1'b1;
                irq_expected_o <= irq_expected_o + 1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // comparisons, on falling edges where outputs are stable
    //////////////////////////////////////////////////////////////////////

    always @(negedge trn_clk) begin
        if (reset) begin
            error_count_o = 0;
            check_count_o = 0;
            irq_acked_o   = 0;
            report_done_o <= 1'b0;
            irq_n_prev_q  <= 1'b1;
        end else begin
            if (cfg_interrupt_n_i !== !m_pending) begin
                $display("[ERROR] cfg_interrupt_n_o: got 0x%0h expected 0x%0h",
                         cfg_interrupt_n_i, !m_pending);
                error_count_o = error_count_o + 1;
            end
            if (release_due_q && !cfg_interrupt_n_i) begin
                $display("interrupt request still held one cycle after rdy was low");
                error_count_o = error_count_o + 1;
            end
            if (!irq_n_prev_q && cfg_interrupt_n_i) begin
                if (release_due_q) begin
                    irq_acked_o = irq_acked_o + 1;
                end else begin
                    $display("interrupt request dropped without rdy from the core");
                    error_count_o = error_count_o + 1;
                end
            end
            irq_n_prev_q  <= cfg_interrupt_n_i;
            if (check_armed_q) begin
                check_count_o = check_count_o + 1;
                if (interrupts_enabled_i !== m_enabled) begin
                    $display("[ERROR] interrupts_enabled_o: got 0x%0h expected 0x%0h",
                             interrupts_enabled_i, m_enabled);
                    error_count_o = error_count_o + 1;
                end
                if (interrupt_period_i !== m_period) begin
                    $display("[ERROR] interrupt_period_o: got 0x%08h expected 0x%08h",
                             interrupt_period_i, m_period);
                    error_count_o = error_count_o + 1;
                end
            end
            if (done_i && !report_done_o) begin
                if (irq_acked_o < irq_expected_o) begin
                    $display("missing interrupt: %0d expected but only %0d acknowledged",
                             irq_expected_o, irq_acked_o);
                    error_count_o = error_count_o + 1;
                end else if (irq_acked_o > irq_expected_o) begin
                    $display("extra interrupt: %0d expected but %0d acknowledged",
                             irq_expected_o, irq_acked_o);
                    error_count_o = error_count_o + 1;
                end
                report_done_o <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb_intr_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_intr_ctrl
    import intr_pkg::*;
();

    localparam int          CLK_PERIOD_NS = 8;
    localparam logic [31:0] LFSR_SEED     = 32'd72593;
    localparam logic [31:0] LFSR_TAPS     = 32'hA300_0000;  // x^32+x^30+x^26+x^25+1
    localparam int          NUM_TLPS      = 300;
    localparam int          BEAT_GAP_MAX  = 3;
    localparam int          TLP_GAP_MAX   = 7;
    localparam int          STALL_MAX     = 2;      // back to back rdst stalls per beat
    localparam int          RSP_DELAY_MAX = 5;
    localparam int          QUIET_CYCLES  = 8;
    localparam int          QUIET_EVERY   = 10;
    localparam int          TLP_CYCLES_MAX = 3 * (BEAT_GAP_MAX + STALL_MAX + 1) + TLP_GAP_MAX
                                           + RSP_DELAY_MAX + QUIET_CYCLES + 2;
    localparam int          WATCHDOG_NS   = NUM_TLPS * TLP_CYCLES_MAX * CLK_PERIOD_NS * 2;

    logic        trn_clk;
    logic        reset;
    logic [63:0] trn_rd;
    logic        trn_rsof_n;
    logic        trn_rsrc_rdy_n;
    logic        trn_rdst_rdy_n;
    logic [6:0]  trn_rbar_hit_n;
    logic        cfg_interrupt_rdy_n;
    wire         cfg_interrupt_n;
    wire         interrupts_enabled;
    wire  [31:0] interrupt_period;
    logic [31:0] lfsr_q;
    logic        issue_pend;        // set after a rising edge, forwarded on the fall
    logic        issue_check;
    reg_op_e     issue_op;
    logic [31:0] issue_data;
    logic        model_wr;
    reg_op_e     model_op;
    logic [31:0] model_data;
    logic        check_req;
    logic        all_done;
    int          rsp_delay;
    int          error_count;
    int          check_count;
    int          irq_expected;
    int          irq_acked;
    logic        report_done;

    intr_ctrl_top intr_ctrl_top_inst (
        .trn_clk(trn_clk), .reset(reset),
        .trn_rd_i(trn_rd), .trn_rsof_n_i(trn_rsof_n),
        .trn_rsrc_rdy_n_i(trn_rsrc_rdy_n), .trn_rdst_rdy_n_i(trn_rdst_rdy_n),
        .trn_rbar_hit_n_i(trn_rbar_hit_n), .cfg_interrupt_rdy_n_i(cfg_interrupt_rdy_n),
        .cfg_interrupt_n_o(cfg_interrupt_n), .interrupts_enabled_o(interrupts_enabled),
        .interrupt_period_o(interrupt_period)
    );

    tb_intr_checker tb_intr_checker_inst (
        .trn_clk(trn_clk), .reset(reset),
        .model_wr_i(model_wr), .model_op_i(model_op), .model_data_i(model_data),
        .check_req_i(check_req), .done_i(all_done),
        .interrupts_enabled_i(interrupts_enabled), .interrupt_period_i(interrupt_period),
        .cfg_interrupt_n_i(cfg_interrupt_n), .cfg_interrupt_rdy_n_i(cfg_interrupt_rdy_n),
        .error_count_o(error_count), .check_count_o(check_count),
        .irq_expected_o(irq_expected), .irq_acked_o(irq_acked), .report_done_o(report_done)
    );

    initial begin
        trn_clk = 1'b0;
        forever #(CLK_PERIOD_NS / 2) trn_clk = ~trn_clk;
    end

    // galois lfsr, one step per bit handed out
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ LFSR_TAPS) : (lfsr_q >> 1);
            v      = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // trn receive driver
    //////////////////////////////////////////////////////////////////////

    task automatic drive_beat(input logic [63:0] data, input logic sof, input logic [6:0] bar_n,
                              input logic issue, input reg_op_e op, input logic [31:0] cmd_data);
        int   stalls;
        logic stall;
        logic taken;
        stalls = 0;
        taken  = 1'b0;
        while (!taken) begin
            @(negedge trn_clk);
            stall          = (take_bits(2) == 0) && (stalls < STALL_MAX);
            trn_rd         = data;
            trn_rsof_n     = !sof;
            trn_rbar_hit_n = bar_n;
            trn_rsrc_rdy_n = 1'b0;
            trn_rdst_rdy_n = stall;             // stalled beat is not counted
            @(posedge trn_clk);
            stalls = stalls + 1;
            taken  = !stall;
        end
        if (issue) begin
            issue_op   = op;
            issue_data = cmd_data;
            issue_pend = 1'b1;
        end
    endtask

    task automatic idle_cycles(input int n);
        logic [31:0] junk;
        repeat (n) begin
            @(negedge trn_clk);
            junk           = take_bits(32);
            trn_rsrc_rdy_n = 1'b1;              // sof and bar garbage, no beat
            trn_rsof_n     = junk[0];
            trn_rbar_hit_n = junk[7:1];
            trn_rdst_rdy_n = junk[8];
            trn_rd         = {junk, ~junk};
            @(posedge trn_clk);
        end
    endtask

    task automatic quiet_check();
        idle_cycles(QUIET_CYCLES);
        issue_check = 1'b1;
        idle_cycles(2);
    endtask

    task automatic send_tlp();
        logic [1:0]  fmt_sel;
        logic [1:0]  bar_sel;
        logic [2:0]  ofs_sel;
        logic [31:0] data;
        logic [31:0] fill_a;
        logic [31:0] fill_b;
        logic [5:0]  ofs;
        logic [6:0]  bar_n;
        logic [6:0]  fmt_type;
        logic        hit;
        reg_op_e     op;
        fmt_sel = take_bits(2);
        bar_sel = take_bits(2);
        ofs_sel = take_bits(3);
        data    = take_bits(32);
        fill_a  = take_bits(32);
        fill_b  = take_bits(32);
        bar_n   = 7'h7F;
        if (bar_sel != 2'd0) bar_n[REG_BAR] = 1'b0;
        else bar_n[0] = 1'b0;                   // some other bar
        op  = OP_ENABLE;
        ofs = fill_b[5:0];
        case (ofs_sel)
            3'd0: begin ofs = OFS_ENABLE;  op = OP_ENABLE;  end
            3'd1: begin ofs = OFS_DISABLE; op = OP_DISABLE; end
            3'd2: begin ofs = OFS_PERIOD;  op = OP_PERIOD;  end
            3'd3: begin ofs = OFS_RTT;     op = OP_RTT;     end
            default: if (ofs[5:2] == 4'b0010) ofs[5] = 1'b1;   // keep off the map
        endcase
        case (fmt_sel)
            2'd0:    fmt_type = MEM_WR32_FMT_TYPE;
            2'd1:    fmt_type = MEM_WR64_FMT_TYPE;
            2'd2:    fmt_type = 7'b00_00000;    // memory read
            default: fmt_type = 7'b10_01010;    // completion with data
        endcase
        hit = (fmt_sel < 2'd2) && (bar_sel != 2'd0) && (ofs_sel < 3'd4);
        drive_beat({1'b0, fmt_type, 24'h00_0001, 32'h0100_000F}, 1'b1, bar_n, 1'b0, op, data);
        idle_cycles(take_bits(2));
        if (fmt_sel == 2'd0) begin
            drive_beat({fill_a[31:8], ofs, 2'b00, data}, 1'b0, bar_n, hit, op, data);
        end else if (fmt_sel == 2'd1) begin
            drive_beat({fill_a, fill_b[31:8], ofs, 2'b00}, 1'b0, bar_n,
                       hit && (op != OP_PERIOD), op, 32'h0);
            idle_cycles(take_bits(2));
            drive_beat({data, fill_b}, 1'b0, bar_n, hit && (op == OP_PERIOD), op, data);
        end else begin
            drive_beat({fill_a, fill_b}, 1'b0, bar_n, 1'b0, op, data);
        end
        rsp_delay = take_bits(3) % (RSP_DELAY_MAX + 1);
    endtask

    // hands driver notes to the checker on the falling edge
    always @(negedge trn_clk) begin
        model_wr    = issue_pend;
        model_op    = issue_op;
        model_data  = issue_data;
        check_req   = issue_check;
        issue_pend  = 1'b0;
        issue_check = 1'b0;
    end

    // core side, acks a request after a random delay
    always begin
        @(negedge trn_clk);
        if (!reset && !cfg_interrupt_n) begin
            repeat (rsp_delay) @(negedge trn_clk);
            cfg_interrupt_rdy_n = 1'b0;
            @(negedge trn_clk);
            cfg_interrupt_rdy_n = 1'b1;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        int t;
        lfsr_q = LFSR_SEED;
        reset = 1'b1;
        trn_rd = '0;
        trn_rsof_n = 1'b1;
        trn_rsrc_rdy_n = 1'b1;
        trn_rdst_rdy_n = 1'b1;
        trn_rbar_hit_n = 7'h7F;
        cfg_interrupt_rdy_n = 1'b1;
        issue_pend = 1'b0;
        issue_check = 1'b0;
        issue_op = OP_ENABLE;
        issue_data = '0;
        all_done = 1'b0;
        rsp_delay = 0;
        repeat (3) @(posedge trn_clk);
        @(negedge trn_clk);
        reset = 1'b0;
        quiet_check();                          // reset levels
        for (t = 0; t < NUM_TLPS; t++) begin
            send_tlp();
            idle_cycles(take_bits(3));
            if ((t % QUIET_EVERY) == QUIET_EVERY - 1) quiet_check();
        end
        idle_cycles(RSP_DELAY_MAX + 4);         // let the last ack land
        quiet_check();
        all_done = 1'b1;
        wait (report_done == 1'b1);
        $display("checks=%0d irq_expected=%0d irq_acked=%0d errors=%0d",
                 check_count, irq_expected, irq_acked, error_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
intr_pkg.sv
tlp_reg_decoder.sv
reg_cmd_fifo.sv
intr_ctrl_regs.sv
intr_ctrl_top.sv
tb_intr_checker.sv
tb_intr_ctrl.sv

// ==== Bender.yml ====
package:
  name: intr_ctrl

sources:
  - intr_pkg.sv
  - tlp_reg_decoder.sv
  - reg_cmd_fifo.sv
  - intr_ctrl_regs.sv
  - intr_ctrl_top.sv
  - target: test
    files:
      - tb_intr_checker.sv
      - tb_intr_ctrl.sv
